// File: include/l1iCache_defines.svh
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// L1 instruction cache widths and codes
// Address, line, index, window and step sizes, plus
// the memory opcode and status encodings
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`ifndef L1I_CACHE_DEFINES_SVH
`define L1I_CACHE_DEFINES_SVH

`define L1I_PC_W        32      // Byte address
`define L1I_OFS_W       4       // Byte offset inside a 16-byte line
`define L1I_LINE_W      128
`define L1I_IX_W        6       // 64 lines per bank
`define L1I_WIN_W       96      // Six 16-bit words
`define L1I_STEP_W      3       // Step in 16-bit words

// Memory opcode
`define L1I_OPM_W       5
`define L1I_OPM_READY   5'h00
`define L1I_OPM_RDTILE  5'h07

// Memory status codes that the fetch status reuses
`define L1I_OK_W        2
`define L1I_OK_READY    2'b00
`define L1I_OK_OK       2'b01
`define L1I_OK_HOLD     2'b10

`endif

// File: hdl/l1iPkg.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// L1 instruction cache types
// Vector typedefs and the enums for the memory
// handshake and the miss fill FSM
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`default_nettype none

`include "l1iCache_defines.svh"

package l1iPkg;

	typedef logic [`L1I_PC_W-1:0] pcAddr_t;

	// PC bits 31:4
	typedef logic [`L1I_PC_W-`L1I_OFS_W-1:0] lineAddr_t;

	typedef logic [`L1I_IX_W-1:0] lineIx_t;
	typedef logic [`L1I_LINE_W-1:0] lineData_t;
	typedef logic [`L1I_WIN_W-1:0] fetchWin_t;
	typedef logic [`L1I_STEP_W-1:0] pcStep_t;

	typedef enum logic [`L1I_OPM_W-1:0]
	{
		opmReady  = `L1I_OPM_READY,
		opmRdTile = `L1I_OPM_RDTILE
	} memOpm_t;

	// Memory side status and core side fetch status
	typedef enum logic [`L1I_OK_W-1:0]
	{
		okReady = `L1I_OK_READY,
		okOk    = `L1I_OK_OK,
		okHold  = `L1I_OK_HOLD
	} memOk_t;

	typedef enum logic [1:0]
	{
		fillIdle,
		fillReq,
		fillDone    // Waiting for memory to drop back to ready
	} fillState_t;

endpackage

`default_nettype wire

// File: hdl/l1iBank.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// One direct-mapped L1I bank
// Data and tag arrays, valid mask, registered read
// with hit compare, and the fill write port
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps
`default_nettype none

`include "l1iCache_defines.svh"

module l1iBank
(
	input  wire logic               clock,
	input  wire logic               arstN,
	input  wire l1iPkg::lineAddr_t  rdLine,
	output l1iPkg::lineData_t       rdData,
	output logic                    hit,
	output l1iPkg::lineAddr_t       reqLine,
	input  wire logic               wrEn,
	input  wire l1iPkg::lineData_t  wrData,
	input  wire logic               flush
);

	localparam int NumLines = 2 ** `L1I_IX_W;

	l1iPkg::lineData_t dataMem [NumLines];
	l1iPkg::lineAddr_t tagMem [NumLines];   // Full line address as tag
	logic [NumLines-1:0] validMask;

	l1iPkg::lineIx_t rdIx;
	l1iPkg::lineIx_t wrIx;
	l1iPkg::lineAddr_t rdTag;
	logic rdValid;
	logic wrFwd;

	// Bit 0 picks the bank, so the index starts at bit 1
	assign rdIx = rdLine[`L1I_IX_W:1];
	assign wrIx = reqLine[`L1I_IX_W:1];

	// Fill lands on the line being re-read
	assign wrFwd = wrEn && (rdIx == wrIx);

	always_ff @(posedge clock or negedge arstN)
	begin
		if (!arstN)
		begin
			validMask <= '0;
			rdValid <= 1'b0;
			reqLine <= '0;
		end
		else
		begin
			reqLine <= rdLine;
			if (flush)                      // Flush beats a same-edge fill
				validMask <= '0;
			else if (wrEn)
				validMask[wrIx] <= 1'b1;

			if (flush)
				rdValid <= 1'b0;
			else if (wrFwd)
				rdValid <= 1'b1;
			else
				rdValid <= validMask[rdIx];
		end
	end

	always_ff @(posedge clock)
	begin
		if (wrEn)
		begin
			dataMem[wrIx] <= wrData;
			tagMem[wrIx] <= reqLine;
		end

		if (wrFwd)
		begin
			rdData <= wrData;
			rdTag <= reqLine;
		end
		else
		begin
			rdData <= dataMem[rdIx];
			rdTag <= tagMem[rdIx];
		end
	end

	assign hit = rdValid && (rdTag == reqLine);

endmodule

`default_nettype wire

// File: hdl/l1iFetchAlign.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Fetch window alignment and length decode
// Picks 96 bits at the PC from two lines and works
// out the PC step in 16-bit words
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps
`default_nettype none

`include "l1iCache_defines.svh"

module l1iFetchAlign
(
	input  wire l1iPkg::pcAddr_t    reqPc,
	input  wire l1iPkg::lineData_t  dataA,
	input  wire l1iPkg::lineData_t  dataB,
	input  wire logic               wxe,
	output l1iPkg::fetchWin_t       fetchWin,
	output l1iPkg::pcStep_t         pcStep
);

	l1iPkg::lineData_t curLine;
	l1iPkg::lineData_t nxtLine;
	logic [2*`L1I_LINE_W-1:0] pairData;
	logic [2:0] wordOfs;
	logic [7:0] hiByte0;
	logic [7:0] hiByte2;
	logic long0;
	logic wide0;
	logic wide2;

	// 32-bit forms live in E0..FF
	function automatic logic opIsLong(input logic [7:0] hiByte);
		opIsLong = (hiByte[7:5] == 3'b111);
	endfunction

	// Ops that may be bundled under wide execute
	function automatic logic opIsWide(input logic [7:0] hiByte);
		logic wide;
		casez (hiByte)
			8'b1111_01??: wide = 1'b1;      // F4..F7
			8'b1111_11??: wide = 1'b1;      // FC..FF
			8'b1110_101?: wide = 1'b1;      // EA/EB
			8'b1110_111?: wide = 1'b1;      // EE/EF
			default:      wide = 1'b0;
		endcase
		opIsWide = wide;
	endfunction

	// Bit 4 set means the odd line (bank B) holds the PC
	assign curLine = reqPc[4] ? dataB : dataA;
	assign nxtLine = reqPc[4] ? dataA : dataB;
	assign pairData = {nxtLine, curLine};

	assign wordOfs = reqPc[3:1];
	assign fetchWin = pairData[wordOfs*16 +: `L1I_WIN_W];

	assign hiByte0 = fetchWin[15:8];
	assign hiByte2 = fetchWin[47:40];   // Op following a 32-bit word 0

	assign long0 = opIsLong(hiByte0);
	assign wide0 = opIsWide(hiByte0);
	assign wide2 = opIsWide(hiByte2);

	always_comb
	begin
		if (wxe && wide0)
		begin
			// Bundle of two or three 32-bit ops
			if (wide2)
				pcStep = l1iPkg::pcStep_t'(6);
			else
				pcStep = l1iPkg::pcStep_t'(4);
		end
		else if (long0)
			pcStep = l1iPkg::pcStep_t'(2);
		else
			pcStep = l1iPkg::pcStep_t'(1);
	end

endmodule

`default_nettype wire

// File: hdl/l1iMissFill.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// L1I miss fill
// Serves bank misses one line at a time, bank A
// first, over the memory tile-read handshake
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps
`default_nettype none

`include "l1iCache_defines.svh"

module l1iMissFill
(
	input  wire logic               clock,
	input  wire logic               arstN,
	input  wire logic               hitA,
	input  wire logic               hitB,
	input  wire l1iPkg::lineAddr_t  reqLineA,
	input  wire l1iPkg::lineAddr_t  reqLineB,
	input  wire l1iPkg::memOk_t     memOk,
	input  wire l1iPkg::lineData_t  memData,
	output l1iPkg::pcAddr_t         memAddr,
	output l1iPkg::memOpm_t         memOpm,
	output logic                    wrEnA,
	output logic                    wrEnB,
	output l1iPkg::lineData_t       wrData
);

	l1iPkg::fillState_t state;
	logic fillB;        // Current fill targets bank B
	logic missA;
	logic missB;
	logic startFill;
	logic lineBack;

	assign missA = !hitA;
	assign missB = !hitB;

	assign startFill = (state == l1iPkg::fillIdle) && (missA || missB) &&
		(memOk == l1iPkg::okReady);
	assign lineBack = (state == l1iPkg::fillReq) && (memOk == l1iPkg::okOk);

	always_ff @(posedge clock or negedge arstN)
	begin
		if (!arstN)
		begin
			state <= l1iPkg::fillIdle;
			memOpm <= l1iPkg::opmReady;
			fillB <= 1'b0;
			wrEnA <= 1'b0;
			wrEnB <= 1'b0;
		end
		else
		begin
			wrEnA <= 1'b0;      // Write pulses last one cycle
			wrEnB <= 1'b0;
			case (state)
				l1iPkg::fillIdle:
				begin
					if (startFill)
					begin
						fillB <= !missA;
						memOpm <= l1iPkg::opmRdTile;
						state <= l1iPkg::fillReq;
					end
				end
				l1iPkg::fillReq:
				begin
					if (lineBack)
					begin
						memOpm <= l1iPkg::opmReady;
						wrEnA <= !fillB;
						wrEnB <= fillB;
						state <= l1iPkg::fillDone;
					end
				end
				l1iPkg::fillDone:
				begin
					// Let the write reach the bank before looking at hits again
					if ((memOk == l1iPkg::okReady) && !wrEnA && !wrEnB)
						state <= l1iPkg::fillIdle;
				end
				default:
					state <= l1iPkg::fillIdle;
			endcase
		end
	end

	always_ff @(posedge clock)
	begin
		if (startFill)
		begin
			if (missA)
				memAddr <= {reqLineA, {`L1I_OFS_W{1'b0}}};
			else
				memAddr <= {reqLineB, {`L1I_OFS_W{1'b0}}};
		end

		if (lineBack)
			wrData <= memData;  // Tile held until the bank write
	end

endmodule

`default_nettype wire

// File: hdl/l1iCache.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Two-bank L1 instruction cache
// Even lines in bank A, odd lines in bank B, so a
// fetch always sees the PC line and the next one
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps
`default_nettype none

`include "l1iCache_defines.svh"

module l1iCache
(
	input  wire logic               clock,
	input  wire logic               arstN,
	input  wire l1iPkg::pcAddr_t    pc,
	input  wire logic               pcHold,
	input  wire logic               pcWxe,
	input  wire logic               flushReq,
	output l1iPkg::fetchWin_t       fetchWin,
	output l1iPkg::memOk_t          fetchOk,
	output l1iPkg::pcStep_t         pcStep,
	input  wire l1iPkg::lineData_t  memData,
	input  wire l1iPkg::memOk_t     memOk,
	output l1iPkg::pcAddr_t         memAddr,
	output l1iPkg::memOpm_t         memOpm
);

	l1iPkg::pcAddr_t effPc;
	l1iPkg::pcAddr_t pcReg;
	logic effWxe;
	logic wxeReg;
	logic pcValid;      // A PC has been taken since reset

	l1iPkg::lineAddr_t pcLine;
	l1iPkg::lineAddr_t nxtLine;
	l1iPkg::lineAddr_t rdLineA;
	l1iPkg::lineAddr_t rdLineB;
	l1iPkg::lineAddr_t reqLineA;
	l1iPkg::lineAddr_t reqLineB;
	l1iPkg::lineData_t dataA;
	l1iPkg::lineData_t dataB;
	l1iPkg::lineData_t wrData;
	logic hitA;
	logic hitB;
	logic wrEnA;
	logic wrEnB;

	// Hold mux
	assign effPc = pcHold ? pcReg : pc;
	assign effWxe = pcHold ? wxeReg : pcWxe;

	always_ff @(posedge clock or negedge arstN)
	begin
		if (!arstN)
		begin
			pcReg <= '0;
			wxeReg <= 1'b0;
			pcValid <= 1'b0;
		end
		else
		begin
			pcReg <= effPc;
			wxeReg <= effWxe;
			pcValid <= 1'b1;
		end
	end

	assign pcLine = effPc[`L1I_PC_W-1:`L1I_OFS_W];
	assign nxtLine = pcLine + l1iPkg::lineAddr_t'(1);

	// Swap the pair when the PC line is odd
	assign rdLineA = effPc[4] ? nxtLine : pcLine;
	assign rdLineB = effPc[4] ? pcLine : nxtLine;

	l1iBank bankA
	(
		.clock   (clock),
		.arstN   (arstN),
		.rdLine  (rdLineA),
		.rdData  (dataA),
		.hit     (hitA),
		.reqLine (reqLineA),
		.wrEn    (wrEnA),
		.wrData  (wrData),
		.flush   (flushReq)
	);

	l1iBank bankB
	(
		.clock   (clock),
		.arstN   (arstN),
		.rdLine  (rdLineB),
		.rdData  (dataB),
		.hit     (hitB),
		.reqLine (reqLineB),
		.wrEn    (wrEnB),
		.wrData  (wrData),
		.flush   (flushReq)
	);

	l1iFetchAlign fetchAlign
	(
		.reqPc    (pcReg),
		.dataA    (dataA),
		.dataB    (dataB),
		.wxe      (wxeReg),
		.fetchWin (fetchWin),
		.pcStep   (pcStep)
	);

	// No fill until a real PC has been registered
	l1iMissFill missFill
	(
		.clock    (clock),
		.arstN    (arstN),
		.hitA     (hitA || !pcValid),
		.hitB     (hitB || !pcValid),
		.reqLineA (reqLineA),
		.reqLineB (reqLineB),
		.memOk    (memOk),
		.memData  (memData),
		.memAddr  (memAddr),
		.memOpm   (memOpm),
		.wrEnA    (wrEnA),
		.wrEnB    (wrEnB),
		.wrData   (wrData)
	);

	assign fetchOk = (hitA && hitB) ? l1iPkg::okOk : l1iPkg::okHold;

endmodule

`default_nettype wire

// File: sim/l1iMemModel.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// L1I testbench memory
// Answers tile reads after a short hold and counts
// the reads it has accepted
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps
`default_nettype none

module l1iMemModel
(
	input  wire logic               clock,
	input  wire logic               arstN,
	input  wire l1iPkg::memOpm_t    memOpm,
	input  wire l1iPkg::pcAddr_t    memAddr,
	output l1iPkg::memOk_t          memOk,
	output l1iPkg::lineData_t       memData,
	output l1iPkg::pcAddr_t         tileAddr,   // Latched request address
	input  wire l1iPkg::lineData_t  tileData,   // Line contents for tileAddr
	input  wire logic [1:0]         delay,
	output int                      readCount
);

	logic [1:0] waitCnt;

	always @(posedge clock or negedge arstN)
	begin
		if (!arstN)
		begin
			memOk <= l1iPkg::okReady;
			tileAddr <= '0;
			waitCnt <= '0;
			readCount <= 0;
		end
		else
		begin
			case (memOk)
				l1iPkg::okReady:
				begin
					if (memOpm == l1iPkg::opmRdTile)
					begin
						tileAddr <= memAddr;
						waitCnt <= delay;
						readCount <= readCount + 1;
						memOk <= l1iPkg::okHold;
					end
				end
				l1iPkg::okHold:
				begin
					if (waitCnt == 2'd0)
						memOk <= l1iPkg::okOk;
					else
						waitCnt <= waitCnt - 2'd1;
				end
				default:
					memOk <= l1iPkg::okReady;  // okOk lasts one cycle
			endcase
		end
	end

	assign memData = (memOk == l1iPkg::okOk) ? tileData : '0;

endmodule

`default_nettype wire

// File: sim/l1iCacheTb.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// L1I cache testbench
// Runs a table of fetches through the cache and
// checks window, step and memory reads
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps
`default_nettype none

module l1iCacheTb;

	localparam int FetchTimeout = 200;     // Cycles

	typedef struct packed
	{
		l1iPkg::pcAddr_t pc;
		logic wxe;
		logic flush;
		logic [1:0] reads;  // New tile reads expected
	} stimEntry_t;

	logic clock = 1'b0;
	logic arstN;
	l1iPkg::pcAddr_t pc;
	logic pcHold;
	logic pcWxe;
	logic flushReq;
	l1iPkg::fetchWin_t fetchWin;
	l1iPkg::memOk_t fetchOk;
	l1iPkg::pcStep_t pcStep;
	l1iPkg::lineData_t memData;
	l1iPkg::memOk_t memOk;
	l1iPkg::pcAddr_t memAddr;
	l1iPkg::memOpm_t memOpm;
	l1iPkg::pcAddr_t tileAddr;
	l1iPkg::lineData_t tileData;
	logic [31:0] delayRng;
	int readCount;
	l1iPkg::lineAddr_t expLine;    // Line pair of the current entry
	stimEntry_t stim [$];

	always #10 clock = ~clock;

	l1iCache DUT
	(
		.clock    (clock),
		.arstN    (arstN),
		.pc       (pc),
		.pcHold   (pcHold),
		.pcWxe    (pcWxe),
		.flushReq (flushReq),
		.fetchWin (fetchWin),
		.fetchOk  (fetchOk),
		.pcStep   (pcStep),
		.memData  (memData),
		.memOk    (memOk),
		.memAddr  (memAddr),
		.memOpm   (memOpm)
	);

	l1iMemModel mem
	(
		.clock     (clock),
		.arstN     (arstN),
		.memOpm    (memOpm),
		.memAddr   (memAddr),
		.memOk     (memOk),
		.memData   (memData),
		.tileAddr  (tileAddr),
		.tileData  (tileData),
		.delay     (delayRng[1:0]),
		.readCount (readCount)
	);

	function automatic logic [31:0] xorshift(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		xorshift = y ^ (y << 5);
	endfunction

	// High bytes cycling through short, long and wide opcodes
	function automatic logic [7:0] hiPattern(input logic [2:0] ix);
		case (ix)
			3'd0: hiPattern = 8'hF5;
			3'd1: hiPattern = 8'h31;
			3'd2: hiPattern = 8'hFD;
			3'd3: hiPattern = 8'hE2;
			3'd4: hiPattern = 8'hEA;
			3'd5: hiPattern = 8'h7C;
			3'd6: hiPattern = 8'hE6;
			default: hiPattern = 8'hEF;
		endcase
	endfunction

	function automatic l1iPkg::lineData_t makeLine(input l1iPkg::lineAddr_t ln);
		logic [31:0] rng;
		logic [2:0] pIx;
		l1iPkg::lineData_t data;
		rng = xorshift(32'd66787 ^ (32'(ln) * 32'h9E37_79B9));
		for (int k = 0; k < 8; k++)
		begin
			rng = xorshift(rng);
			pIx = ln[2:0] + 3'(k);
			data[k*16 +: 16] = {hiPattern(pIx), rng[7:0]};
		end
		makeLine = data;
	endfunction

	function automatic logic isWide(input logic [7:0] b);
		isWide = (b >= 8'hF4 && b <= 8'hF7) || (b >= 8'hFC) ||
			b == 8'hEA || b == 8'hEB || b == 8'hEE || b == 8'hEF;
	endfunction

	// Six words from the PC line followed by the next line
	function automatic l1iPkg::fetchWin_t expectedWin(input l1iPkg::pcAddr_t addr);
		l1iPkg::lineAddr_t ln;
		logic [255:0] pair;
		int base;
		ln = addr[31:4];
		pair = {makeLine(ln + 28'd1), makeLine(ln)};
		base = 16 * int'(addr[3:1]);
		expectedWin = pair[base +: 96];
	endfunction

	function automatic l1iPkg::pcStep_t expectedStep(input l1iPkg::pcAddr_t addr,
		input logic wxe);
		l1iPkg::fetchWin_t win;
		logic [7:0] b0;
		logic [7:0] b2;
		win = expectedWin(addr);
		b0 = win[15:8];
		b2 = win[47:40];
		if (wxe && isWide(b0))
			expectedStep = isWide(b2) ? 3'd6 : 3'd4;
		else
			expectedStep = (b0 >= 8'hE0) ? 3'd2 : 3'd1;
	endfunction

	task automatic checkWindow(input l1iPkg::fetchWin_t got, input l1iPkg::fetchWin_t exp,
		input l1iPkg::pcAddr_t at);
		if (got !== exp)
		begin
			$display("FAILED at %0t ns: pc %h window %h, expected %h", $time, at, got, exp);
			$display("TESTS FAILED");
			$fatal(1, "fetch window mismatch");
		end
	endtask

	task automatic compareStep(input l1iPkg::pcStep_t got, input l1iPkg::pcStep_t exp,
		input l1iPkg::pcAddr_t at);
		if (got !== exp)
		begin
			$display("FAILED at %0t ns: pc %h step %0d, expected %0d", $time, at, got, exp);
			$display("TESTS FAILED");
			$fatal(1, "pc step mismatch");
		end
	endtask

	task automatic verifyReadCount(input int got, input int exp, input l1iPkg::pcAddr_t at);
		if (got != exp)
		begin
			$display("FAILED at %0t ns: pc %h read count %0d, expected %0d", $time, at, got, exp);
			$display("TESTS FAILED");
			$fatal(1, "tile read count mismatch");
		end
	endtask

	task automatic tileAddrCheck(input l1iPkg::pcAddr_t got, input l1iPkg::pcAddr_t expLo,
		input l1iPkg::pcAddr_t expHi);
		if (got !== expLo && got !== expHi)
		begin
			$display("FAILED at %0t ns: tile read at %h, expected %h or %h",
				$time, got, expLo, expHi);
			$display("TESTS FAILED");
			$fatal(1, "tile address mismatch");
		end
	endtask

	task automatic waitFetchOk(input l1iPkg::pcAddr_t at);
		int cycles;
		cycles = 0;
		@(negedge clock);
		while (fetchOk != l1iPkg::okOk && cycles < FetchTimeout)
		begin
			@(negedge clock);
			cycles++;
		end
		if (fetchOk != l1iPkg::okOk)
		begin
			$display("Timeout: fetchOk never reached okOk for pc %h", at);
			$display("TESTS FAILED");
			$fatal(1, "fetch wait timed out");
		end
	endtask

	task automatic addStim(input l1iPkg::pcAddr_t a, input logic w, input logic f,
		input logic [1:0] r);
		stim.push_back('{pc: a, wxe: w, flush: f, reads: r});
	endtask

	always @(posedge clock)
		delayRng <= xorshift(delayRng);

	assign tileData = makeLine(tileAddr[31:4]);

	// Each accepted request must target the PC line or the one after
	always @(posedge clock)
	begin
		if (arstN && memOk == l1iPkg::okReady && memOpm == l1iPkg::opmRdTile)
			tileAddrCheck(memAddr, {expLine, 4'h0}, {expLine + 28'd1, 4'h0});
	end

	initial
	begin
		stimEntry_t ent;
		int expCount;
		addStim(32'h0000_1000, 1'b0, 1'b0, 2'd2);     // Cold fetch misses both banks
		addStim(32'h0000_1002, 1'b0, 1'b0, 2'd0);
		addStim(32'h0000_1004, 1'b1, 1'b0, 2'd0);
		addStim(32'h0000_1006, 1'b0, 1'b0, 2'd0);
		addStim(32'h0000_1008, 1'b1, 1'b0, 2'd0);
		addStim(32'h0000_100A, 1'b0, 1'b0, 2'd0);
		addStim(32'h0000_100C, 1'b1, 1'b0, 2'd0);
		addStim(32'h0000_100E, 1'b1, 1'b0, 2'd0);     // Crosses into the odd line
		addStim(32'h0000_1000, 1'b1, 1'b0, 2'd0);
		addStim(32'h0000_1010, 1'b0, 1'b0, 2'd1);     // Odd line first and the next line misses
		addStim(32'h0000_101C, 1'b1, 1'b0, 2'd0);
		addStim(32'h0000_101E, 1'b0, 1'b0, 2'd0);
		addStim(32'h0000_1800, 1'b1, 1'b0, 2'd2);     // Aliases index 0 in both banks
		addStim(32'h0000_1000, 1'b0, 1'b0, 2'd2);     // Refill after eviction
		addStim(32'h0000_1012, 1'b1, 1'b0, 2'd0);
		addStim(32'h0000_1004, 1'b1, 1'b1, 2'd2);     // Flush then refetch
		addStim(32'h0000_2010, 1'b1, 1'b0, 2'd2);
		addStim(32'h0000_201E, 1'b0, 1'b0, 2'd0);
		addStim(32'h0000_201A, 1'b1, 1'b0, 2'd0);
		addStim(32'h0000_2014, 1'b0, 1'b1, 2'd2);     // Both lines cached before the flush

		// First PC is already presented during reset
		arstN = 1'b0;
		pc = stim[0].pc;
		pcWxe = stim[0].wxe;
		pcHold = 1'b0;
		flushReq = 1'b0;
		delayRng = 32'd66787;
		expLine = stim[0].pc[31:4];
		expCount = 0;
		repeat (2) @(posedge clock);
		arstN <= 1'b1;

		foreach (stim[i])
		begin
			ent = stim[i];
			expLine = ent.pc[31:4];
			expCount += int'(ent.reads);
			@(posedge clock);
			pc <= ent.pc;
			pcWxe <= ent.wxe;
			pcHold <= 1'b0;
			flushReq <= ent.flush;
			@(posedge clock);
			pcHold <= 1'b1;     // Hold until the fetch completes
			flushReq <= 1'b0;
			waitFetchOk(ent.pc);
			checkWindow(fetchWin, expectedWin(ent.pc), ent.pc);
			compareStep(pcStep, expectedStep(ent.pc, ent.wxe), ent.pc);
			verifyReadCount(readCount, expCount, ent.pc);
		end

		$display("TESTS PASSED");
		$finish;
	end

endmodule

`default_nettype wire

// File: flist.f
+incdir+include
hdl/l1iPkg.sv
hdl/l1iBank.sv
hdl/l1iFetchAlign.sv
hdl/l1iMissFill.sv
hdl/l1iCache.sv
sim/l1iMemModel.sv
sim/l1iCacheTb.sv

// File: Makefile
SIM     := verilator
FLAGS   := --binary --timing
TOP     := l1iCacheTb
FLIST   := flist.f

OBJDIR  := obj_dir
SIMBIN  := $(OBJDIR)/V$(TOP)
SOURCES := $(shell grep -v '^+' $(FLIST)) $(wildcard include/*.svh)

.PHONY: all run clean

all: $(SIMBIN)

$(SIMBIN): $(SOURCES) $(FLIST)
	$(SIM) $(FLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FLIST)

run: $(SIMBIN)
	./$(SIMBIN)

clean:
	rm -rf $(OBJDIR)
